// File: addr_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module addr_router (
    input  logic      clk,
    input  logic      rst,
    mem_bus_if.slave  up,
    mem_bus_if.master sram_port,
    mem_bus_if.master clint_port
);
    import axi_pkg::*;

    logic rd_sram;
    logic rd_clint;
    logic wr_sram;
    logic rerr_q; // pending decerr on r
    logic werr_q; // pending decerr on b

    // the lsu holds its address until the response, so decode stays valid
    assign rd_sram  = (up.araddr >= `SRAM_BASE) && (up.araddr < `SRAM_BASE + 4 * `SRAM_WORDS);
    assign rd_clint = (up.araddr >= `CLINT_BASE) && (up.araddr <= `CLINT_END);
    assign wr_sram  = (up.awaddr >= `SRAM_BASE) && (up.awaddr < `SRAM_BASE + 4 * `SRAM_WORDS);

    assign sram_port.arvalid  = up.arvalid & rd_sram;
    assign sram_port.araddr   = up.araddr;
    assign sram_port.rready   = up.rready & rd_sram;
    assign clint_port.arvalid = up.arvalid & rd_clint;
    assign clint_port.araddr  = up.araddr;
    assign clint_port.rready  = up.rready & rd_clint;

    assign up.arready = rd_sram ? sram_port.arready : rd_clint ? clint_port.arready : ~rerr_q;
    assign up.rvalid  = rd_sram ? sram_port.rvalid  : rd_clint ? clint_port.rvalid  : rerr_q;
    assign up.rdata   = rd_sram ? sram_port.rdata   : rd_clint ? clint_port.rdata   : '0;
    assign up.rresp   = rd_sram ? sram_port.rresp   : rd_clint ? clint_port.rresp   : RESP_DECERR;

    // writes go to sram only, timer writes fall into the error path
    assign sram_port.awvalid = up.awvalid & wr_sram;
    assign sram_port.awaddr  = up.awaddr;
    assign sram_port.wvalid  = up.wvalid & wr_sram;
    assign sram_port.wdata   = up.wdata;
    assign sram_port.wstrb   = up.wstrb;
    assign sram_port.bready  = up.bready & wr_sram;

    assign clint_port.awvalid = 1'b0;
    assign clint_port.awaddr  = '0;
    assign clint_port.wvalid  = 1'b0;
    assign clint_port.wdata   = '0;
    assign clint_port.wstrb   = '0;
    assign clint_port.bready  = 1'b0;

    assign up.awready = wr_sram ? sram_port.awready : ~werr_q;
    assign up.wready  = wr_sram ? sram_port.wready  : ~werr_q;
    assign up.bvalid  = wr_sram ? sram_port.bvalid  : werr_q;
    assign up.bresp   = wr_sram ? sram_port.bresp   : RESP_DECERR;

    always_ff @(posedge clk) begin
        if (rst) begin
            rerr_q <= 1'b0;
            werr_q <= 1'b0;
        end else begin
            if (rerr_q && up.rready)
                rerr_q <= 1'b0;
            if (up.arvalid && up.arready && !rd_sram && !rd_clint)
                rerr_q <= 1'b1;
            if (werr_q && up.bready)
                werr_q <= 1'b0;
            if (up.awvalid && up.awready && !wr_sram)
                werr_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: axi_pkg.sv
`default_nettype none

`include "lsu_config.svh"

package axi_pkg;

    typedef logic [`LSU_DATA_W-1:0]   addr_t;
    typedef logic [`LSU_DATA_W-1:0]   data_t;
    typedef logic [`LSU_DATA_W/8-1:0] strb_t; // one bit per byte lane

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } resp_e;

endpackage

`default_nettype wire

// File: clint.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module clint (
    input  logic     clk,
    input  logic     rst,
    mem_bus_if.slave bus
);
    import axi_pkg::*;

    logic [2*`LSU_DATA_W-1:0] mtime;
    logic                     rvalid_q;

    assign bus.arready = ~rvalid_q;
    assign bus.rvalid  = rvalid_q;
    assign bus.rresp   = RESP_OKAY;

    // read only, the router answers writes itself
    assign bus.awready = 1'b0;
    assign bus.wready  = 1'b0;
    assign bus.bvalid  = 1'b0;
    assign bus.bresp   = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            rvalid_q <= 1'b0;
        end else begin
            mtime <= mtime + 1'b1; // free running
            if (rvalid_q && bus.rready)
                rvalid_q <= 1'b0;
            if (bus.arvalid && bus.arready)
                rvalid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.arvalid && bus.arready)
            bus.rdata <= bus.araddr[2] ? mtime[2*`LSU_DATA_W-1:`LSU_DATA_W]
                                       : mtime[`LSU_DATA_W-1:0];
    end

endmodule

`default_nettype wire

// File: lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  logic                    wen,
    input  logic                    sign,
    input  lsu_pkg::access_size_e   size,
    input  logic [`LSU_DATA_W-1:0]  addr,
    input  logic [`LSU_DATA_W-1:0]  wdata,
    output logic [`LSU_DATA_W-1:0]  rdata,
    output logic                    done,
    output logic                    busy,
    output logic                    err,
    mem_bus_if.master               bus
);
    import lsu_pkg::*;
    import axi_pkg::*;

    lsu_state_e   state;
    access_size_e size_q;
    logic         sign_q;
    logic         wen_q;
    logic [1:0]   lane;
    logic [1:0]   lane_q;
    strb_t        strb;
    strb_t        strb_q;
    addr_t        addr_q;
    data_t        wdata_q;
    data_t        word_q;
    data_t        shifted;
    data_t        load_val;
    logic         accept;
    logic         resp_q;     // response seen, done follows next cycle
    logic         resp_err_q;

    assign accept = (state == ST_IDLE) && req && !busy;

    // byte lane and strobe; misaligned halves/words fall back to aligned
    always_comb begin
        lane = 2'b00;
        strb = 4'b0000;
        case (size)
            SIZE_BYTE: begin
                lane = addr[1:0];
                strb = 4'b0001 << addr[1:0];
            end
            SIZE_HALF: begin
                lane = {addr[1], 1'b0};
                strb = addr[1] ? 4'b1100 : 4'b0011;
            end
            SIZE_WORD: strb = 4'b1111;
            default:   strb = 4'b0000;
        endcase
    end

    assign bus.araddr = addr_q;
    assign bus.awaddr = addr_q;
    assign bus.wdata  = wdata_q;
    assign bus.wstrb  = strb_q;
    assign bus.rready = (state == ST_WAIT_RD);
    assign bus.bready = (state == ST_WAIT_WR);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            busy        <= 1'b0;
            done        <= 1'b0;
            err         <= 1'b0;
            resp_q      <= 1'b0;
            resp_err_q  <= 1'b0;
            bus.arvalid <= 1'b0;
            bus.awvalid <= 1'b0;
            bus.wvalid  <= 1'b0;
        end else begin
            done   <= resp_q;
            resp_q <= 1'b0;
            if (resp_q)
                err <= resp_err_q; // held until the next done
            if (done)
                busy <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        busy <= 1'b1;
                        if (wen) begin
                            bus.awvalid <= 1'b1;
                            bus.wvalid  <= 1'b1;
                            state       <= ST_WAIT_WR;
                        end else begin
                            bus.arvalid <= 1'b1;
                            state       <= ST_WAIT_RD;
                        end
                    end
                end
                ST_WAIT_RD: begin
                    if (bus.arvalid && bus.arready)
                        bus.arvalid <= 1'b0;
                    if (bus.rvalid && bus.rready) begin
                        resp_q     <= 1'b1;
                        resp_err_q <= (bus.rresp != RESP_OKAY);
                        state      <= ST_IDLE;
                    end
                end
                ST_WAIT_WR: begin
                    if (bus.awvalid && bus.awready)
                        bus.awvalid <= 1'b0;
                    if (bus.wvalid && bus.wready)
                        bus.wvalid <= 1'b0;
                    if (bus.bvalid && bus.bready) begin
                        resp_q     <= 1'b1;
                        resp_err_q <= (bus.bresp != RESP_OKAY);
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request payload and returned data
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= addr;
            size_q  <= size;
            sign_q  <= sign;
            wen_q   <= wen;
            lane_q  <= lane;
            strb_q  <= strb;
            wdata_q <= wdata << {lane, 3'b000}; // move into byte lanes
        end
        if (bus.rvalid && bus.rready)
            word_q <= bus.rdata;
        if (resp_q && !wen_q)
            rdata <= load_val;
    end

    assign shifted = word_q >> {lane_q, 3'b000};

    always_comb begin
        case (size_q)
            SIZE_BYTE: load_val = {{24{shifted[7] & sign_q}}, shifted[7:0]};
            SIZE_HALF: load_val = {{16{shifted[15] & sign_q}}, shifted[15:0]};
            default:   load_val = shifted;
        endcase
    end

endmodule

`default_nettype wire

// File: lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data and address width
`define LSU_DATA_W 32

// local sram region, word organized
`define SRAM_BASE  32'h8000_0000
`define SRAM_WORDS 256

// timer region: offset 0 mtime low, offset 4 mtime high
`define CLINT_BASE 32'h0200_0000
`define CLINT_END  32'h0200_FFFF

`endif

// File: lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // encoding follows the old mask field, 0 is unused
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd1,
        SIZE_HALF = 2'd2,
        SIZE_WORD = 2'd3
    } access_size_e;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_WAIT_RD = 2'd1, // ar issued, waiting for r
        ST_WAIT_WR = 2'd2  // aw/w issued, waiting for b
    } lsu_state_e;

endpackage

`default_nettype wire

// File: lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  logic                    wen,
    input  logic                    sign,
    input  lsu_pkg::access_size_e   size,
    input  logic [`LSU_DATA_W-1:0]  addr,
    input  logic [`LSU_DATA_W-1:0]  wdata,
    output logic [`LSU_DATA_W-1:0]  rdata,
    output logic                    done,
    output logic                    busy,
    output logic                    err
);

    mem_bus_if m_bus ();
    mem_bus_if sram_bus ();
    mem_bus_if clint_bus ();

    lsu u_lsu (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .wen   (wen),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .busy  (busy),
        .err   (err),
        .bus   (m_bus.master)
    );

    addr_router u_router (
        .clk        (clk),
        .rst        (rst),
        .up         (m_bus.slave),
        .sram_port  (sram_bus.master),
        .clint_port (clint_bus.master)
    );

    sram u_sram (
        .clk (clk),
        .rst (rst),
        .bus (sram_bus.slave)
    );

    clint u_clint (
        .clk (clk),
        .rst (rst),
        .bus (clint_bus.slave)
    );

endmodule

`default_nettype wire

// File: mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
    import axi_pkg::*;

    logic  arvalid; // read address
    addr_t araddr;
    logic  arready;

    logic  rvalid;  // read data
    data_t rdata;
    resp_e rresp;
    logic  rready;

    logic  awvalid; // write address
    addr_t awaddr;
    logic  awready;

    logic  wvalid;  // write data
    data_t wdata;
    strb_t wstrb;
    logic  wready;

    logic  bvalid;  // write response
    resp_e bresp;
    logic  bready;

    modport master (
        output arvalid, araddr, rready,
        output awvalid, awaddr, wvalid, wdata, wstrb, bready,
        input  arready, rvalid, rdata, rresp,
        input  awready, wready, bvalid, bresp
    );

    modport slave (
        input  arvalid, araddr, rready,
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
        output arready, rvalid, rdata, rresp,
        output awready, wready, bvalid, bresp
    );

endinterface

`default_nettype wire

// File: sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module sram (
    input  logic     clk,
    input  logic     rst,
    mem_bus_if.slave bus
);
    import axi_pkg::*;

    localparam int IDX_W = $clog2(`SRAM_WORDS);

    data_t            mem [`SRAM_WORDS];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             rvalid_q;
    logic             bvalid_q;

    assign rd_idx = bus.araddr[IDX_W+1:2]; // low bits dropped
    assign wr_idx = bus.awaddr[IDX_W+1:2];

    assign bus.arready = ~rvalid_q;
    assign bus.awready = bus.awvalid & bus.wvalid & ~bvalid_q; // aw and w taken together
    assign bus.wready  = bus.awvalid & bus.wvalid & ~bvalid_q;
    assign bus.rvalid  = rvalid_q;
    assign bus.rresp   = RESP_OKAY;
    assign bus.bvalid  = bvalid_q;
    assign bus.bresp   = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (rvalid_q && bus.rready)
                rvalid_q <= 1'b0;
            if (bus.arvalid && bus.arready)
                rvalid_q <= 1'b1;
            if (bvalid_q && bus.bready)
                bvalid_q <= 1'b0;
            if (bus.awvalid && bus.awready)
                bvalid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.arvalid && bus.arready)
            bus.rdata <= mem[rd_idx];
        if (bus.awvalid && bus.awready) begin
            for (int i = 0; i < `LSU_DATA_W / 8; i++) begin
                if (bus.wstrb[i])
                    mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
axi_pkg.sv
lsu_pkg.sv
mem_bus_if.sv
lsu.sv
addr_router.sv
sram.sv
clint.sv
lsu_top.sv
tb_lsu.sv

// File: tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module tb_lsu;
    import lsu_pkg::*;

    localparam int CLK_NS    = 40;
    localparam int N_WORD    = 16;
    localparam int TIMER_GAP = 37;
    localparam int N_TXN     = 2 * N_WORD + 13 + 13 + 3 + 5;
    localparam int WATCHDOG_NS = (N_TXN * 10 + TIMER_GAP + 100) * CLK_NS;

    logic        clk;
    logic        rst;
    logic        req;
    logic        wen;
    logic        sign;
    access_size_e size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        done;
    logic        busy;
    logic        err;

    logic [7:0]  ref_mem [4*`SRAM_WORDS]; // byte image of the sram region
    int          errors;
    int          checks;
    int          cycle;
    int          last_req_cycle;

    lsu_top uut (
        .clk(clk), .rst(rst), .req(req), .wen(wen), .sign(sign), .size(size),
        .addr(addr), .wdata(wdata), .rdata(rdata), .done(done), .busy(busy), .err(err)
    );

    always #(CLK_NS / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // outputs quiet in and just after reset
    assert property (@(posedge clk) rst |=> (!done && !busy && !err))
        else begin
            errors++;
            $display("outputs active during reset");
        end
    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            errors++;
            $display("done held longer than one cycle");
        end
    assert property (@(posedge clk) disable iff (rst) done |=> !busy)
        else begin
            errors++;
            $display("busy still high after done");
        end
    assert property (@(posedge clk) disable iff (rst) (req && !busy) |=> busy)
        else begin
            errors++;
            $display("busy not raised after an accepted req");
        end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp)
            else begin
                errors++;
                $display("mismatch %s: expected %h, actual %h", name, exp, got);
            end
    endtask

    // lat counts cycles from the req edge to done
    task automatic do_access(input logic w, input logic s, input access_size_e sz,
                             input logic [31:0] a, input logic [31:0] d,
                             output logic [31:0] rd, output logic e, output int lat);
        int n;
        @(negedge clk);
        req = 1'b1;
        wen = w;
        sign = s;
        size = sz;
        addr = a;
        wdata = d;
        last_req_cycle = cycle;
        @(negedge clk);
        req = 1'b0;
        n = 1;
        while (!done && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            errors++;
            $display("no done within 20 cycles for access at %h", a);
        end
        lat = n;
        rd = rdata;
        e = err;
    endtask

    function automatic logic [31:0] pick_sram_addr();
        return `SRAM_BASE + ($urandom % `SRAM_WORDS) * 4;
    endfunction

    task automatic apply_store(input access_size_e sz, input logic [31:0] a, input logic [31:0] d);
        int off;
        off = a - `SRAM_BASE;
        case (sz)
            SIZE_BYTE: ref_mem[off] = d[7:0];
            SIZE_HALF: for (int i = 0; i < 2; i++) ref_mem[(off & ~1) + i] = d[8*i +: 8];
            default:   for (int i = 0; i < 4; i++) ref_mem[(off & ~3) + i] = d[8*i +: 8];
        endcase
    endtask

    function automatic logic [31:0] expected_load(input access_size_e sz, input logic s,
                                                  input logic [31:0] a);
        int off;
        logic [15:0] h;
        off = a - `SRAM_BASE;
        h = {ref_mem[(off & ~1) + 1], ref_mem[off & ~1]};
        case (sz)
            SIZE_BYTE: return {{24{s & ref_mem[off][7]}}, ref_mem[off]};
            SIZE_HALF: return {{16{s & h[15]}}, h};
            default:   return {ref_mem[(off & ~3) + 3], ref_mem[(off & ~3) + 2],
                               ref_mem[(off & ~3) + 1], ref_mem[off & ~3]};
        endcase
    endfunction

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [31:0] addrs [N_WORD];
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] rd;
        logic [31:0] t1;
        logic [31:0] t2;
        logic        e;
        int          lat;
        int          c1;
        int          c2;
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        wen = 1'b0;
        sign = 1'b0;
        size = SIZE_WORD;
        addr = '0;
        wdata = '0;
        errors = 0;
        checks = 0;
        void'($urandom(3813));
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_val("reset quiet", 32'd0, {done, busy, err});

        // mtime high is still zero this early
        do_access(1'b0, 1'b0, SIZE_WORD, `CLINT_BASE + 4, 0, rd, e, lat);
        check_val("mtime high", 32'd0, rd);

        for (int i = 0; i < N_WORD; i++) begin
            addrs[i] = pick_sram_addr();
            d = $urandom;
            do_access(1'b1, 1'b0, SIZE_WORD, addrs[i], d, rd, e, lat);
            apply_store(SIZE_WORD, addrs[i], d);
            check_val("word store err", 32'd0, e);
        end
        for (int i = 0; i < N_WORD; i++) begin
            do_access(1'b0, 1'b0, SIZE_WORD, addrs[i], 0, rd, e, lat);
            check_val("word load", expected_load(SIZE_WORD, 1'b0, addrs[i]), rd);
            check_val("word load latency", 32'd4, lat);
            check_val("word load err", 32'd0, e);
        end

        // sub-word stores only touch the addressed lanes
        a = pick_sram_addr();
        d = $urandom;
        do_access(1'b1, 1'b0, SIZE_WORD, a, d, rd, e, lat);
        apply_store(SIZE_WORD, a, d);
        for (int off = 0; off < 4; off++) begin
            d = $urandom;
            do_access(1'b1, 1'b0, SIZE_BYTE, a + off, d, rd, e, lat);
            apply_store(SIZE_BYTE, a + off, d);
            do_access(1'b0, 1'b0, SIZE_WORD, a, 0, rd, e, lat);
            check_val($sformatf("byte store off %0d", off), expected_load(SIZE_WORD, 1'b0, a), rd);
        end
        for (int off = 0; off < 4; off += 2) begin
            d = $urandom;
            do_access(1'b1, 1'b0, SIZE_HALF, a + off, d, rd, e, lat);
            apply_store(SIZE_HALF, a + off, d);
            do_access(1'b0, 1'b0, SIZE_WORD, a, 0, rd, e, lat);
            check_val($sformatf("half store off %0d", off), expected_load(SIZE_WORD, 1'b0, a), rd);
        end

        // lanes mix set and clear sign bits
        a = pick_sram_addr();
        do_access(1'b1, 1'b0, SIZE_WORD, a, 32'h7F80_F15C, rd, e, lat);
        apply_store(SIZE_WORD, a, 32'h7F80_F15C);
        for (int s = 0; s < 2; s++) begin
            for (int off = 0; off < 4; off++) begin
                do_access(1'b0, s[0], SIZE_BYTE, a + off, 0, rd, e, lat);
                check_val($sformatf("byte load off %0d sign %0d", off, s),
                          expected_load(SIZE_BYTE, s[0], a + off), rd);
            end
            for (int off = 0; off < 4; off += 2) begin
                do_access(1'b0, s[0], SIZE_HALF, a + off, 0, rd, e, lat);
                check_val($sformatf("half load off %0d sign %0d", off, s),
                          expected_load(SIZE_HALF, s[0], a + off), rd);
            end
        end

        do_access(1'b0, 1'b0, SIZE_WORD, `CLINT_BASE, 0, t1, e, lat);
        c1 = last_req_cycle;
        repeat (TIMER_GAP) @(negedge clk);
        do_access(1'b0, 1'b0, SIZE_WORD, `CLINT_BASE, 0, t2, e, lat);
        c2 = last_req_cycle;
        check_val("mtime increasing", 32'd1, {31'd0, t2 > t1});
        check_val("mtime delta", c2 - c1, t2 - t1);

        do_access(1'b0, 1'b0, SIZE_WORD, 32'h1000_0000, 0, rd, e, lat);
        check_val("unmapped load err", 32'd1, e);
        do_access(1'b1, 1'b0, SIZE_WORD, 32'h4000_0000, $urandom, rd, e, lat);
        check_val("unmapped store err", 32'd1, e);
        do_access(1'b1, 1'b0, SIZE_WORD, `CLINT_BASE, 32'hFFFF_FFFF, rd, e, lat);
        check_val("timer store err", 32'd1, e);
        do_access(1'b0, 1'b0, SIZE_WORD, addrs[0], 0, rd, e, lat);
        check_val("load after errors", expected_load(SIZE_WORD, 1'b0, addrs[0]), rd);
        check_val("load after errors err", 32'd0, e);
        do_access(1'b0, 1'b0, SIZE_WORD, `CLINT_BASE, 0, t2, e, lat);
        check_val("mtime after errors", last_req_cycle - c1, t2 - t1);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
